/* logic/ll_pkg.sv */
`default_nettype none

// page chain layout shared by the deallocator and the link table
package ll_pkg;

  // words per page and the line index that selects one of them
  localparam int ll_lines = 4;
  localparam int ll_line_w = 2;

  // link replies are page_aw+1 bits wide
  // top bit set means end of chain, low bits are then don't care
  // replies are widened to this size before the helper looks at them
  localparam int ll_reply_max_w = 32;

  function automatic logic ll_is_end(
    input int unsigned page_aw,
    input logic [ll_reply_max_w-1:0] reply
  );
    return reply[page_aw];
  endfunction

endpackage

`default_nettype wire

/* logic/pb_pkg.sv */
`default_nettype none

// packet word layout in the buffer
package pb_pkg;

  // payload bits of one buffer word
  localparam int pb_data_w = 64;

  // position of a word inside its packet
  typedef enum logic [1:0] {
    pcc_mid     = 2'd0,
    pcc_sop     = 2'd1,
    pcc_eop     = 2'd2,
    pcc_sop_eop = 2'd3
  } pcc_t;

  // full word is {pcc, payload}
  localparam int pb_pcc_w = 2;
  localparam int pb_pcc_lsb = pb_data_w;
  localparam int pb_word_w = pb_data_w + pb_pcc_w;

  // true for the last word of a packet, single word packets included
  function automatic logic any_eop(input pcc_t pcc);
    return (pcc == pcc_eop) || (pcc == pcc_sop_eop);
  endfunction

endpackage

`default_nettype wire

/* logic/dealloc_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// packet buffer read, request half and return half
interface pb_rd_if #(
  parameter int page_aw = 4
) ();
  import ll_pkg::*;
  import pb_pkg::*;

  logic                         req_srdy;
  logic                         req_drdy;
  logic [page_aw+ll_line_w-1:0] req_addr;

  logic                         rtn_srdy;
  logic                         rtn_drdy;
  logic [pb_word_w-1:0]         rtn_data;

  modport requester (output req_srdy, req_addr, rtn_drdy,
                     input  req_drdy, rtn_srdy, rtn_data);
  modport server    (input  req_srdy, req_addr, rtn_drdy,
                     output req_drdy, rtn_srdy, rtn_data);
endinterface

// link table read, page request and next page reply
interface link_rd_if #(
  parameter int page_aw = 4
) ();
  logic               lrq_srdy;
  logic               lrq_drdy;
  logic [page_aw-1:0] lrq_page;

  logic               lrp_srdy;
  logic               lrp_drdy;
  logic [page_aw:0]   lrp_data;

  modport requester (output lrq_srdy, lrq_page, lrp_drdy,
                     input  lrq_drdy, lrp_srdy, lrp_data);
  modport server    (input  lrq_srdy, lrq_page, lrp_drdy,
                     output lrq_drdy, lrp_srdy, lrp_data);
endinterface

`default_nettype wire

/* logic/sd_iohalf.sv */
`timescale 1ns/1ps
`default_nettype none

// single slot srdy/drdy buffer
// input side only sees drdy when the slot is empty, so a word can
// not enter in the cycle the previous one leaves
module sd_iohalf #(
  parameter int width = 8
) (
  input  wire              clk,
  input  wire              reset,

  input  wire              c_srdy,
  output logic             c_drdy,
  input  wire [width-1:0]  c_data,

  output logic             p_srdy,
  input  wire              p_drdy,
  output logic [width-1:0] p_data
);

  logic full;

  assign c_drdy = !full;
  assign p_srdy = full;

  always_ff @(posedge clk)
  begin
    if (reset)
      full <= 1'b0;
    else if (c_srdy && !full)
      full <= 1'b1;
    else if (p_srdy && p_drdy)
      full <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (c_srdy && !full)
      p_data <= c_data;
  end

  // a stalled producer keeps its word until the slot takes it
  a_in_held : assert property (@(posedge clk) disable iff (reset)
    (c_srdy && !c_drdy) |=> (c_srdy && $stable(c_data)));

endmodule

`default_nettype wire

/* logic/deallocator.sv */
`timescale 1ns/1ps
`default_nettype none

// walks a packet's page chain, reads it out word by word and hands
// the first and last page back for freeing
module deallocator #(
  parameter int page_aw = 4
) (
  input  wire                           clk,
  input  wire                           reset,

  input  wire                           f2d_srdy,
  output logic                          f2d_drdy,
  input  wire [page_aw-1:0]             f2d_page,

  pb_rd_if.requester                    pbr,
  link_rd_if.requester                  lnk,

  output logic                          ptx_srdy,
  input  wire                           ptx_drdy,
  output logic [pb_pkg::pb_word_w-1:0]  ptx_data,

  output logic                          drf_srdy,
  input  wire                           drf_drdy,
  output logic [page_aw-1:0]            drf_first,
  output logic [page_aw-1:0]            drf_last
);
  import ll_pkg::*;
  import pb_pkg::*;

  typedef enum logic [2:0] {idle, fetch, link, link_reply, ret} dealloc_state_t;

  localparam logic [ll_line_w-1:0] last_line = ll_line_w'(ll_lines - 1);

  dealloc_state_t       state, nxt_state;
  logic [page_aw-1:0]   first_page, cur_page;
  logic [ll_line_w-1:0] lcount;
  logic                 page_done, eop_seen, pb_req;
  logic                 start_fire, req_fire, ptx_fire, ptx_eop;
  logic                 lrp_fire, lrp_end, take_link;

  assign start_fire = f2d_srdy && f2d_drdy;
  assign req_fire   = pbr.req_srdy && pbr.req_drdy;
  assign ptx_fire   = ptx_srdy && ptx_drdy;
  assign lrp_fire   = lnk.lrp_srdy && lnk.lrp_drdy;
  assign ptx_eop    = any_eop(pcc_t'(ptx_data[pb_word_w-1:pb_pcc_lsb]));
  assign lrp_end    = ll_is_end(page_aw, ll_reply_max_w'(lnk.lrp_data));
  // after eop the reply is ignored, the packet ends on this page
  assign take_link  = lrp_fire && !eop_seen && !lrp_end;

  assign pbr.req_addr = {cur_page, lcount};
  assign lnk.lrq_page = cur_page;
  assign drf_first    = first_page;
  assign drf_last     = cur_page;

  sd_iohalf #(.width(pb_word_w)) i_rtn_buf (
    .clk    (clk),
    .reset  (reset),
    .c_srdy (pbr.rtn_srdy),
    .c_drdy (pbr.rtn_drdy),
    .c_data (pbr.rtn_data),
    .p_srdy (ptx_srdy),
    .p_drdy (ptx_drdy),
    .p_data (ptx_data)
  );

  always_comb
  begin
    nxt_state    = state;
    f2d_drdy     = 1'b0;
    pbr.req_srdy = 1'b0;
    lnk.lrq_srdy = 1'b0;
    lnk.lrp_drdy = 1'b0;
    drf_srdy     = 1'b0;
    case (state)
      idle:
      begin
        f2d_drdy = 1'b1;
        if (f2d_srdy)
          nxt_state = fetch;
      end
      // one read in flight, wait for its word to leave before the next
      fetch:
      begin
        if (!pb_req)
        begin
          if (eop_seen || page_done)
            nxt_state = link;
          else
            pbr.req_srdy = 1'b1;
        end
      end
      link:
      begin
        lnk.lrq_srdy = 1'b1;
        if (lnk.lrq_drdy)
          nxt_state = link_reply;
      end
      link_reply:
      begin
        lnk.lrp_drdy = 1'b1;
        if (lnk.lrp_srdy)
          nxt_state = (eop_seen || lrp_end) ? ret : fetch;
      end
      ret:
      begin
        drf_srdy = 1'b1;
        if (drf_drdy)
          nxt_state = idle;
      end
      default: nxt_state = idle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= idle;
      lcount    <= '0;
      page_done <= 1'b0;
      eop_seen  <= 1'b0;
      pb_req    <= 1'b0;
    end
    else
    begin
      state <= nxt_state;
      if (ptx_fire)
        pb_req <= 1'b0;
      else if (req_fire)
        pb_req <= 1'b1;
      if (start_fire)
      begin
        lcount    <= '0;
        page_done <= 1'b0;
        eop_seen  <= 1'b0;
      end
      else
      begin
        if (ptx_fire && ptx_eop)
          eop_seen <= 1'b1;
        if (req_fire)
        begin
          lcount <= lcount + 1'b1;
          if (lcount == last_line)
            page_done <= 1'b1;
        end
        // line count has already wrapped to zero for the new page
        if (take_link)
          page_done <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (start_fire)
    begin
      first_page <= f2d_page;
      cur_page   <= f2d_page;
    end
    else if (take_link)
      cur_page <= lnk.lrp_data[page_aw-1:0];
  end

  // no word of an earlier read may still sit in the return path
  a_one_outstanding : assert property (@(posedge clk) disable iff (reset)
    req_fire |-> (!pbr.rtn_srdy && !ptx_srdy));

  // pages go back only once the last word has left
  a_drf_after_words : assert property (@(posedge clk) disable iff (reset)
    drf_srdy |-> (!pbr.rtn_srdy && !ptx_srdy));

endmodule

`default_nettype wire

/* logic/link_table.sv */
`timescale 1ns/1ps
`default_nettype none

// next page memory, read through a registered reply slot
module link_table #(
  parameter int page_aw = 4
) (
  input  wire               clk,
  input  wire               reset,

  input  wire               wr_en,
  input  wire [page_aw-1:0] wr_page,
  input  wire [page_aw:0]   wr_next,

  link_rd_if.server         lnk
);

  logic [page_aw:0] next_mem [0:(2**page_aw)-1];
  logic             lrp_full;
  logic             lrq_fire;

  // request goes in when the reply slot is free or being taken now
  assign lnk.lrq_drdy = !lrp_full || lnk.lrp_drdy;
  assign lnk.lrp_srdy = lrp_full;
  assign lrq_fire     = lnk.lrq_srdy && lnk.lrq_drdy;

  always_ff @(posedge clk)
  begin
    if (wr_en)
      next_mem[wr_page] <= wr_next;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      lrp_full <= 1'b0;
    else if (lrq_fire)
      lrp_full <= 1'b1;
    else if (lnk.lrp_drdy)
      lrp_full <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (lrq_fire)
      lnk.lrp_data <= next_mem[lnk.lrq_page];
  end

  // a waiting page request holds until it is taken
  a_req_held : assert property (@(posedge clk) disable iff (reset)
    (lnk.lrq_srdy && !lnk.lrq_drdy) |=> (lnk.lrq_srdy && $stable(lnk.lrq_page)));

endmodule

`default_nettype wire

/* logic/pkt_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

// packet word memory, addressed as {page, line}
module pkt_buffer #(
  parameter int page_aw = 4
) (
  input  wire                                   clk,
  input  wire                                   reset,

  input  wire                                   wr_en,
  input  wire [page_aw+ll_pkg::ll_line_w-1:0]   wr_addr,
  input  wire [pb_pkg::pb_word_w-1:0]           wr_data,

  pb_rd_if.server                               pbr
);
  import ll_pkg::*;
  import pb_pkg::*;

  localparam int depth = 2 ** (page_aw + ll_line_w);

  logic [pb_word_w-1:0] word_mem [0:depth-1];
  logic                 rtn_full;
  logic                 req_fire;

  assign pbr.req_drdy = !rtn_full || pbr.rtn_drdy;
  assign pbr.rtn_srdy = rtn_full;
  assign req_fire     = pbr.req_srdy && pbr.req_drdy;

  always_ff @(posedge clk)
  begin
    if (wr_en)
      word_mem[wr_addr] <= wr_data;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      rtn_full <= 1'b0;
    else if (req_fire)
      rtn_full <= 1'b1;
    else if (pbr.rtn_drdy)
      rtn_full <= 1'b0;
  end

  // return word only changes when a new read replaces it
  always_ff @(posedge clk)
  begin
    if (req_fire)
      pbr.rtn_data <= word_mem[pbr.req_addr];
  end

  // a stalled read request keeps its address until accepted
  a_req_held : assert property (@(posedge clk) disable iff (reset)
    (pbr.req_srdy && !pbr.req_drdy) |=> (pbr.req_srdy && $stable(pbr.req_addr)));

endmodule

`default_nettype wire

/* logic/dealloc_top.sv */
`timescale 1ns/1ps
`default_nettype none

// read-out side of the shared packet buffer
module dealloc_top #(
  parameter int page_aw = 4
) (
  input  wire                                   clk,
  input  wire                                   reset,

  input  wire                                   f2d_srdy,
  output logic                                  f2d_drdy,
  input  wire [page_aw-1:0]                     f2d_page,

  output logic                                  ptx_srdy,
  input  wire                                   ptx_drdy,
  output logic [pb_pkg::pb_word_w-1:0]          ptx_data,

  output logic                                  drf_srdy,
  input  wire                                   drf_drdy,
  output logic [page_aw-1:0]                    drf_first,
  output logic [page_aw-1:0]                    drf_last,

  // table and buffer fill ports
  input  wire                                   link_wr_en,
  input  wire [page_aw-1:0]                     link_wr_page,
  input  wire [page_aw:0]                       link_wr_next,
  input  wire                                   pb_wr_en,
  input  wire [page_aw+ll_pkg::ll_line_w-1:0]   pb_wr_addr,
  input  wire [pb_pkg::pb_word_w-1:0]           pb_wr_data
);

  pb_rd_if   #(.page_aw(page_aw)) pbr ();
  link_rd_if #(.page_aw(page_aw)) lnk ();

  deallocator #(.page_aw(page_aw)) i_deallocator (
    .clk       (clk),
    .reset     (reset),
    .f2d_srdy  (f2d_srdy),
    .f2d_drdy  (f2d_drdy),
    .f2d_page  (f2d_page),
    .pbr       (pbr.requester),
    .lnk       (lnk.requester),
    .ptx_srdy  (ptx_srdy),
    .ptx_drdy  (ptx_drdy),
    .ptx_data  (ptx_data),
    .drf_srdy  (drf_srdy),
    .drf_drdy  (drf_drdy),
    .drf_first (drf_first),
    .drf_last  (drf_last)
  );

  link_table #(.page_aw(page_aw)) i_link_table (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (link_wr_en),
    .wr_page (link_wr_page),
    .wr_next (link_wr_next),
    .lnk     (lnk.server)
  );

  pkt_buffer #(.page_aw(page_aw)) i_pkt_buffer (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (pb_wr_en),
    .wr_addr (pb_wr_addr),
    .wr_data (pb_wr_data),
    .pbr     (pbr.server)
  );

endmodule

`default_nettype wire

/* testbench/tb_dealloc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dealloc_top;
  import pb_pkg::*;

  localparam int page_aw = 4;
  // longest word count over all tests, sizes the watchdog
  localparam int max_words = 100;
  localparam int watchdog_cycles = 40 * max_words + 200;

  logic clk = 1'b0;
  logic reset;
  logic f2d_srdy;
  logic f2d_drdy;
  logic [page_aw-1:0] f2d_page;
  logic ptx_srdy;
  logic ptx_drdy;
  logic [pb_word_w-1:0] ptx_data;
  logic drf_srdy;
  logic drf_drdy;
  logic [page_aw-1:0] drf_first;
  logic [page_aw-1:0] drf_last;
  logic link_wr_en;
  logic [page_aw-1:0] link_wr_page;
  logic [page_aw:0] link_wr_next;
  logic pb_wr_en;
  logic [page_aw+1:0] pb_wr_addr;
  logic [pb_word_w-1:0] pb_wr_data;

  integer seed = 32'hf9d2_6ce5;
  string test_name = "reset";
  logic ptx_bp = 1'b0;
  logic drf_stall = 1'b0;

  // testbench copies of the link table and the buffer
  logic [page_aw:0] link_img [0:15];
  logic [pb_word_w-1:0] buf_img [0:63];
  logic [page_aw-1:0] perm [0:15];
  int alloc_ptr;
  logic [page_aw-1:0] start_q [$];
  int len_q [$];

  logic [pb_word_w-1:0] exp_word_q [$];
  int exp_tag_q [$];
  logic [2*page_aw-1:0] exp_pair_q [$];
  logic [pb_word_w-1:0] exp_w;
  int exp_tag;
  logic [2*page_aw-1:0] exp_p;
  int pkt_serial = 0;
  int drf_done = 0;
  int words_seen = 0;
  int pairs_seen = 0;
  int word_errors = 0;
  int pair_errors = 0;
  int other_errors = 0;

  always #4 clk = ~clk;

  dealloc_top #(.page_aw(page_aw)) i_dut (
    .clk          (clk),
    .reset        (reset),
    .f2d_srdy     (f2d_srdy),
    .f2d_drdy     (f2d_drdy),
    .f2d_page     (f2d_page),
    .ptx_srdy     (ptx_srdy),
    .ptx_drdy     (ptx_drdy),
    .ptx_data     (ptx_data),
    .drf_srdy     (drf_srdy),
    .drf_drdy     (drf_drdy),
    .drf_first    (drf_first),
    .drf_last     (drf_last),
    .link_wr_en   (link_wr_en),
    .link_wr_page (link_wr_page),
    .link_wr_next (link_wr_next),
    .pb_wr_en     (pb_wr_en),
    .pb_wr_addr   (pb_wr_addr),
    .pb_wr_data   (pb_wr_data)
  );

  // walk the chain line by line, stop at eop or at the end marker
  function automatic logic [2*page_aw-1:0] expected_stream(
    input logic [page_aw-1:0] start,
    input int length,
    input int tag
  );
    logic [page_aw-1:0] page;
    logic [pb_word_w-1:0] w;
    logic [1:0] code;
    int line;
    int n;
    page = start;
    line = 0;
    n = 0;
    while (n < length)
    begin
      w = buf_img[{page, 2'(line)}];
      exp_word_q.push_back(w);
      exp_tag_q.push_back(tag);
      n++;
      code = w[pb_word_w-1:pb_data_w];
      if (code == pcc_eop || code == pcc_sop_eop)
        break;
      line++;
      if (line == 4)
      begin
        if (link_img[page][page_aw])
          break;
        page = link_img[page][page_aw-1:0];
        line = 0;
      end
    end
    return {start, page};
  endfunction

  task automatic write_link(input logic [page_aw-1:0] page, input logic [page_aw:0] next);
    link_wr_en = 1'b1;
    link_wr_page = page;
    link_wr_next = next;
    link_img[page] = next;
    @(posedge clk);
    #1;
    link_wr_en = 1'b0;
  endtask

  task automatic write_word(input logic [page_aw+1:0] addr, input logic [pb_word_w-1:0] w);
    pb_wr_en = 1'b1;
    pb_wr_addr = addr;
    pb_wr_data = w;
    buf_img[addr] = w;
    @(posedge clk);
    #1;
    pb_wr_en = 1'b0;
  endtask

  // fresh shuffle of the pages so chains jump around the buffer
  task automatic new_test(input string name);
    int j;
    logic [page_aw-1:0] t;
    test_name = name;
    start_q.delete();
    len_q.delete();
    for (int i = 0; i < 16; i++)
      perm[i] = 4'(i);
    for (int i = 15; i > 0; i--)
    begin
      j = $unsigned($random(seed)) % (i + 1);
      t = perm[i];
      perm[i] = perm[j];
      perm[j] = t;
    end
    alloc_ptr = 0;
  endtask

  // lines past the packet end get filler words
  task automatic add_packet(input int length, input int n_pages);
    logic [page_aw-1:0] pg [0:3];
    pcc_t code;
    for (int k = 0; k < n_pages; k++)
    begin
      pg[k] = perm[alloc_ptr];
      alloc_ptr++;
    end
    for (int k = 0; k < n_pages; k++)
    begin
      if (k == n_pages - 1)
        write_link(pg[k], {1'b1, 4'($random(seed))});
      else
        write_link(pg[k], {1'b0, pg[k+1]});
    end
    for (int i = 0; i < 4 * n_pages; i++)
    begin
      if (i >= length)
        code = pcc_mid;
      else if (length == 1)
        code = pcc_sop_eop;
      else if (i == 0)
        code = pcc_sop;
      else if (i == length - 1)
        code = pcc_eop;
      else
        code = pcc_mid;
      write_word({pg[i/4], 2'(i % 4)}, {code, $random(seed), $random(seed)});
    end
    start_q.push_back(pg[0]);
    len_q.push_back(length);
  endtask

  task automatic offer_start(input logic [page_aw-1:0] page);
    f2d_srdy = 1'b1;
    f2d_page = page;
    @(negedge clk);
    while (!f2d_drdy)
      @(negedge clk);
    @(posedge clk);
    #1;
    f2d_srdy = 1'b0;
  endtask

  task automatic run_packets();
    for (int i = 0; i < start_q.size(); i++)
    begin
      exp_pair_q.push_back(expected_stream(start_q[i], len_q[i], pkt_serial));
      pkt_serial++;
      offer_start(start_q[i]);
    end
    while (exp_word_q.size() != 0 || exp_pair_q.size() != 0)
      @(posedge clk);
    #1;
  endtask

  task automatic set_flow(input logic bp, input logic stall);
    @(negedge clk);
    ptx_bp = bp;
    drf_stall = stall;
    @(posedge clk);
    #1;
  endtask

  // ptx and drf ready, random when the flags ask for it
  initial
  begin : drdy_driver
    logic [31:0] r;
    int hold_cnt;
    logic holding;
    ptx_drdy = 1'b1;
    drf_drdy = 1'b1;
    hold_cnt = 0;
    holding = 1'b0;
    forever
    begin
      @(posedge clk);
      #1;
      if (ptx_bp)
      begin
        r = $random(seed);
        ptx_drdy = r[0] | r[1];
      end
      else
        ptx_drdy = 1'b1;
      if (drf_stall && drf_srdy)
      begin
        if (!holding)
        begin
          r = $random(seed);
          hold_cnt = 2 + int'(r[3:0]);
          holding = 1'b1;
        end
        drf_drdy = (hold_cnt == 0);
        if (hold_cnt > 0)
          hold_cnt--;
      end
      else
      begin
        drf_drdy = 1'b1;
        holding = 1'b0;
      end
    end
  end

  always @(negedge clk)
  begin
    if (!reset && ptx_srdy && ptx_drdy)
    begin
      if (exp_word_q.size() == 0)
      begin
        other_errors++;
        $display("Error in %s: a word left on ptx when none was expected", test_name);
      end
      else
      begin
        exp_w = exp_word_q.pop_front();
        exp_tag = exp_tag_q.pop_front();
        words_seen++;
        assert (ptx_data == exp_w)
        else
        begin
          word_errors++;
          $display("Fail %s: expected %h, actual %h", test_name, exp_w, ptx_data);
        end
        // a packet's words only follow the freeing of all earlier packets
        assert (exp_tag == drf_done)
        else
        begin
          word_errors++;
          $display("Fail %s: expected freed count %0d, actual %0d",
                   test_name, exp_tag, drf_done);
        end
      end
    end
  end

  always @(negedge clk)
  begin
    if (!reset && drf_srdy && drf_drdy)
    begin
      if (exp_pair_q.size() == 0)
      begin
        other_errors++;
        $display("Error in %s: drf transfer with no packet pending", test_name);
      end
      else
      begin
        exp_p = exp_pair_q.pop_front();
        pairs_seen++;
        assert ({drf_first, drf_last} == exp_p)
        else
        begin
          pair_errors++;
          $display("Fail %s: expected %h, actual %h", test_name, exp_p, {drf_first, drf_last});
        end
      end
      drf_done <= drf_done + 1;
    end
  end

  initial
  begin
    #(watchdog_cycles * 8);
    $display("Error: watchdog expired after %0d cycles in %s", watchdog_cycles, test_name);
    $display("Simulation FAILED");
    $finish;
  end

  initial
  begin
    int length;
    reset = 1'b1;
    f2d_srdy = 1'b0;
    f2d_page = '0;
    link_wr_en = 1'b0;
    link_wr_page = '0;
    link_wr_next = '0;
    pb_wr_en = 1'b0;
    pb_wr_addr = '0;
    pb_wr_data = '0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    assert (f2d_drdy && !ptx_srdy && !drf_srdy)
    else
    begin
      other_errors++;
      $display("Error: handshake outputs not idle after reset");
    end

    new_test("single_page");
    add_packet(1, 1);
    add_packet(2, 1);
    add_packet(3, 1);
    run_packets();

    new_test("multi_page_full");
    add_packet(12, 3);
    add_packet(8, 2);
    run_packets();

    // chains longer than the packet, eop in an early page
    new_test("early_eop");
    add_packet(6, 4);
    add_packet(2, 3);
    run_packets();

    new_test("ptx_backpressure");
    for (int i = 0; i < 4; i++)
    begin
      length = 1 + $unsigned($random(seed)) % 12;
      add_packet(length, (length + 3) / 4);
    end
    set_flow(1'b1, 1'b0);
    run_packets();
    set_flow(1'b0, 1'b0);

    new_test("drf_stall_back_to_back");
    add_packet(5, 2);
    add_packet(9, 3);
    add_packet(4, 1);
    set_flow(1'b0, 1'b1);
    run_packets();
    set_flow(1'b0, 1'b0);

    $display("Checked %0d words and %0d pairs, errors: word %0d, pair %0d, other %0d",
             words_seen, pairs_seen, word_errors, pair_errors, other_errors);
    if (word_errors == 0 && pair_errors == 0 && other_errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* dealloc_top.f */
logic/ll_pkg.sv
logic/pb_pkg.sv
logic/dealloc_ifs.sv
logic/sd_iohalf.sv
logic/deallocator.sv
logic/link_table.sv
logic/pkt_buffer.sv
logic/dealloc_top.sv
testbench/tb_dealloc_top.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator and run, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dealloc_top \
  -f dealloc_top.f -o tb_sim || exit 1

out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "Simulation PASSED" && exit 0 || exit 1
